// File: design/opn_audio_pkg.sv
/*
  Timing constants and audio types shared by the sequencer,
  the register block, the timers and the DAC.
  Counter widths in the modules assume these exact values.
*/
`default_nettype none

package opn_audio_pkg;

    localparam int CEN_DIV          = 6;   // cen pulses per clk_en
    localparam int SLOTS_PER_SAMPLE = 24;  // Operator slots per sample
    localparam int TIMER_B_PRESCALE = 16;  // Samples per timer B tick
    localparam int BUSY_CEN         = 32;  // Busy length after a data write

    typedef logic signed [15:0] sample_t;

    // Timer settings from registers 0x24 to 0x27
    typedef struct packed {
        logic [9:0] value_a;
        logic [7:0] value_b;
        logic       load_a;
        logic       load_b;
        logic       en_a;
        logic       en_b;
    } timer_cfg_t;

    // Channel-6 DAC settings
    typedef struct packed {
        logic [7:0] pcm;        // Unsigned, 0x80 is silence
        logic       dac_en;
        logic       pan_left;
        logic       pan_right;
    } dac_cfg_t;

endpackage

`default_nettype wire

// File: design/opn_clkgen.sv
/*
  Slot sequencer. clk_en fires on every CEN_DIV-th cen pulse and zero
  marks the slot that closes a sample, once per 144 cen pulses.
  Counter widths fit CEN_DIV = 6 and SLOTS_PER_SAMPLE = 24.
*/
`timescale 1ns/1ns
`default_nettype none

module opn_clkgen
    import opn_audio_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic cen,
    output logic clk_en,
    output logic zero
);

    logic [2:0] cen_cnt;
    logic [4:0] slot_cnt;
    logic       cen_wrap;

    assign cen_wrap = cen && (cen_cnt == 3'(CEN_DIV - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            cen_cnt <= '0;
            clk_en  <= 1'b0;
        end else begin
            clk_en <= cen_wrap;  // Registered one-clk pulse
            if (cen) begin
                cen_cnt <= cen_wrap ? 3'd0 : cen_cnt + 3'd1;
            end
        end
    end

    // Slot position advances on each clk_en
    always_ff @(posedge clk) begin
        if (rst) begin
            slot_cnt <= '0;
        end else if (clk_en) begin
            slot_cnt <= zero ? 5'd0 : slot_cnt + 5'd1;
        end
    end

    // Coincides with the clk_en that wraps the slot count
    assign zero = clk_en && (slot_cnt == 5'(SLOTS_PER_SAMPLE - 1));

endmodule

`default_nettype wire

// File: design/opn_core.sv
/*
  FM chip top level without the FM pipeline, LFO, SSG or ADPCM.
  snd_left and snd_right carry only the channel-6 DAC.
  Hold cen high when no clock enable is needed.
*/
`timescale 1ns/1ns
`default_nettype none

module opn_core
    import opn_audio_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       cen,
    input  logic [7:0] din,
    input  logic [1:0] addr,
    input  logic       cs_n,
    input  logic       wr_n,
    output logic [7:0] dout,
    output logic       irq_n,
    output sample_t    snd_left,
    output sample_t    snd_right,
    output logic       snd_sample
);

    logic       zero;
    logic       flag_a;
    logic       flag_b;
    logic       clr_flag_a;
    logic       clr_flag_b;
    timer_cfg_t timer_cfg;
    dac_cfg_t   dac_cfg;

    opn_clkgen u_clkgen (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .cen        ( cen        ),
        .clk_en     (            ),  // Slot strobe, no operator pipeline to feed
        .zero       ( zero       )
    );

    opn_regs u_regs (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .cen        ( cen        ),
        .din        ( din        ),
        .addr       ( addr       ),
        .cs_n       ( cs_n       ),
        .wr_n       ( wr_n       ),
        .flag_a     ( flag_a     ),
        .flag_b     ( flag_b     ),
        .timer_cfg  ( timer_cfg  ),
        .clr_flag_a ( clr_flag_a ),
        .clr_flag_b ( clr_flag_b ),
        .dac_cfg    ( dac_cfg    ),
        .dout       ( dout       )
    );

    opn_timers u_timers (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .zero       ( zero       ),
        .timer_cfg  ( timer_cfg  ),
        .clr_flag_a ( clr_flag_a ),
        .clr_flag_b ( clr_flag_b ),
        .flag_a     ( flag_a     ),
        .flag_b     ( flag_b     ),
        .irq_n      ( irq_n      )
    );

    opn_dac u_dac (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .zero       ( zero       ),
        .dac_cfg    ( dac_cfg    ),
        .snd_left   ( snd_left   ),
        .snd_right  ( snd_right  ),
        .snd_sample ( snd_sample )
    );

endmodule

`default_nettype wire

// File: design/opn_dac.sv
/*
  Channel-6 PCM DAC. The unsigned byte is offset to signed and scaled
  by 64, then gated by the DAC enable and each pan bit.
  Outputs update one clk after each zero strobe.
*/
`timescale 1ns/1ns
`default_nettype none

module opn_dac
    import opn_audio_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     zero,
    input  dac_cfg_t dac_cfg,
    output sample_t  snd_left,
    output sample_t  snd_right,
    output logic     snd_sample
);

    logic signed [7:0] pcm_s;
    sample_t           dac_sample;

    // pcm - 128 by flipping the top bit
    assign pcm_s = {~dac_cfg.pcm[7], dac_cfg.pcm[6:0]};

    assign dac_sample = dac_cfg.dac_en ? {{2{pcm_s[7]}}, pcm_s, 6'd0} : '0;

    always_ff @(posedge clk) begin
        if (zero) begin
            snd_left  <= dac_cfg.pan_left ? dac_sample : '0;
            snd_right <= dac_cfg.pan_right ? dac_sample : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            snd_sample <= 1'b0;
        end else begin
            snd_sample <= zero;  // Aligned with the new outputs
        end
    end

endmodule

`default_nettype wire

// File: design/opn_reg_pkg.sv
/*
  Register map of the FM sound chip bus interface.
  Only the timer, DAC and channel-6 pan registers are decoded.
  Part I covers 0x24 to 0x2B, part II only the channel-6 pan register.
*/
`default_nettype none

package opn_reg_pkg;

    // Part I addresses
    localparam logic [7:0] REG_TIMER_A_HI = 8'h24;  // Timer A bits 9:2
    localparam logic [7:0] REG_TIMER_A_LO = 8'h25;  // Timer A bits 1:0
    localparam logic [7:0] REG_TIMER_B    = 8'h26;
    localparam logic [7:0] REG_TIMER_CTRL = 8'h27;
    localparam logic [7:0] REG_DAC_DATA   = 8'h2A;
    localparam logic [7:0] REG_DAC_EN     = 8'h2B;  // Enable in bit 7

    // Part II address
    localparam logic [7:0] REG_PAN_CH6    = 8'hB6;

    // Timer control byte, register 0x27
    typedef struct packed {
        logic [1:0] ch3_mode;  // Not used here
        logic       reset_b;
        logic       reset_a;
        logic       en_b;
        logic       en_a;
        logic       load_b;
        logic       load_a;
    } timer_ctrl_t;

    // Pan and modulation byte, register 0xB6
    typedef struct packed {
        logic       left;
        logic       right;
        logic [1:0] ams;       // No LFO, ignored
        logic       rsvd;
        logic [2:0] pms;       // Ignored as well
    } pan_t;

    // Same data byte seen through the latched address
    typedef union packed {
        timer_ctrl_t ctrl;
        pan_t        pan;
        logic [7:0]  raw;
    } reg_data_u;

endpackage

`default_nettype wire

// File: design/opn_regs.sv
/*
  CPU bus register block. addr[0]=0 latches the register address and
  addr[1] the part, addr[0]=1 writes the data byte to it.
  Writes stay accepted while busy. dout always returns the status byte,
  the SSG read path does not exist here.
*/
`timescale 1ns/1ns
`default_nettype none

module opn_regs
    import opn_reg_pkg::*, opn_audio_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       cen,
    input  logic [7:0] din,
    input  logic [1:0] addr,
    input  logic       cs_n,
    input  logic       wr_n,
    input  logic       flag_a,
    input  logic       flag_b,
    output timer_cfg_t timer_cfg,
    output logic       clr_flag_a,
    output logic       clr_flag_b,
    output dac_cfg_t   dac_cfg,
    output logic [7:0] dout
);

    logic       write;
    logic       addr_wr;
    logic       data_wr;
    logic [7:0] reg_addr;
    logic       reg_part;   // 1 selects part II
    logic       hit_part1;
    logic       hit_part2;
    reg_data_u  wdata;
    logic [9:0] value_a;
    logic [7:0] value_b;
    logic       load_a;
    logic       load_b;
    logic       en_a;
    logic       en_b;
    logic       busy;
    logic [4:0] busy_cnt;

    assign write     = ~cs_n & ~wr_n;
    assign addr_wr   = write & ~addr[0];
    assign data_wr   = write & addr[0];
    assign wdata.raw = din;

    assign hit_part1 = ~reg_part && (reg_addr >= REG_TIMER_A_HI) && (reg_addr <= REG_DAC_EN);
    assign hit_part2 = reg_part && (reg_addr == REG_PAN_CH6);

    always_ff @(posedge clk) begin
        if (rst) begin
            reg_addr <= '0;
            reg_part <= 1'b0;
        end else if (addr_wr) begin
            reg_addr <= din;
            reg_part <= addr[1];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            load_a     <= 1'b0;
            load_b     <= 1'b0;
            en_a       <= 1'b0;
            en_b       <= 1'b0;
            clr_flag_a <= 1'b0;
            clr_flag_b <= 1'b0;
            dac_cfg    <= '{pcm: 8'h80, dac_en: 1'b0, pan_left: 1'b1, pan_right: 1'b1};
        end else begin
            clr_flag_a <= 1'b0;  // One-cycle strobes
            clr_flag_b <= 1'b0;
            if (data_wr && hit_part1) begin
                case (reg_addr)
                    REG_TIMER_CTRL: begin
                        load_a     <= wdata.ctrl.load_a;
                        load_b     <= wdata.ctrl.load_b;
                        en_a       <= wdata.ctrl.en_a;
                        en_b       <= wdata.ctrl.en_b;
                        clr_flag_a <= wdata.ctrl.reset_a;
                        clr_flag_b <= wdata.ctrl.reset_b;
                    end
                    REG_DAC_DATA: dac_cfg.pcm    <= wdata.raw;
                    REG_DAC_EN:   dac_cfg.dac_en <= wdata.raw[7];
                    default: ;
                endcase
            end
            if (data_wr && hit_part2) begin
                dac_cfg.pan_left  <= wdata.pan.left;
                dac_cfg.pan_right <= wdata.pan.right;
            end
        end
    end

    // Timer reload values, taken by the timers only on a load edge
    always_ff @(posedge clk) begin
        if (data_wr && hit_part1) begin
            case (reg_addr)
                REG_TIMER_A_HI: value_a[9:2] <= wdata.raw;
                REG_TIMER_A_LO: value_a[1:0] <= wdata.raw[1:0];
                REG_TIMER_B:    value_b      <= wdata.raw;
                default: ;
            endcase
        end
    end

    // Busy covers BUSY_CEN cen pulses after any data write
    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            busy_cnt <= '0;
        end else if (data_wr) begin
            busy     <= 1'b1;
            busy_cnt <= '0;
        end else if (busy && cen) begin
            busy_cnt <= busy_cnt + 5'd1;
            if (busy_cnt == 5'(BUSY_CEN - 1)) begin
                busy <= 1'b0;
            end
        end
    end

    always_comb begin
        timer_cfg.value_a = value_a;
        timer_cfg.value_b = value_b;
        timer_cfg.load_a  = load_a;
        timer_cfg.load_b  = load_b;
        timer_cfg.en_a    = en_a;
        timer_cfg.en_b    = en_b;
    end

    assign dout = {busy, 5'd0, flag_b, flag_a};

endmodule

`default_nettype wire

// File: design/opn_timers.sv
/*
  Timers A and B, both up-counters that reload on overflow.
  They count sample strobes, timer B through a /16 prescaler.
  A flag is only set while its enable bit is on and holds until cleared.
*/
`timescale 1ns/1ns
`default_nettype none

module opn_timers
    import opn_audio_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       zero,
    input  timer_cfg_t timer_cfg,
    input  logic       clr_flag_a,
    input  logic       clr_flag_b,
    output logic       flag_a,
    output logic       flag_b,
    output logic       irq_n
);

    logic       load_a_q;
    logic       load_b_q;
    logic       start_a;
    logic       start_b;
    logic       run_a;
    logic       tick_b;
    logic       ovf_a;
    logic       ovf_b;
    logic [9:0] cnt_a;
    logic [7:0] cnt_b;
    logic [3:0] presc_b;

    assign start_a = timer_cfg.load_a & ~load_a_q;  // Load bit rising
    assign start_b = timer_cfg.load_b & ~load_b_q;

    assign run_a  = zero & timer_cfg.load_a & ~start_a;
    assign tick_b = zero & timer_cfg.load_b & ~start_b
                    & (presc_b == 4'(TIMER_B_PRESCALE - 1));

    assign ovf_a = run_a && (cnt_a == 10'h3FF);
    assign ovf_b = tick_b && (cnt_b == 8'hFF);

    always_ff @(posedge clk) begin
        if (rst) begin
            load_a_q <= 1'b0;
            load_b_q <= 1'b0;
            cnt_a    <= '0;
            cnt_b    <= '0;
            presc_b  <= '0;
        end else begin
            load_a_q <= timer_cfg.load_a;
            load_b_q <= timer_cfg.load_b;

            if (start_a || ovf_a) begin
                cnt_a <= timer_cfg.value_a;
            end else if (run_a) begin
                cnt_a <= cnt_a + 10'd1;
            end

            if (start_b) begin
                presc_b <= '0;
            end else if (zero && timer_cfg.load_b) begin
                presc_b <= presc_b + 4'd1;  // Wraps every 16 samples
            end

            if (start_b || ovf_b) begin
                cnt_b <= timer_cfg.value_b;
            end else if (tick_b) begin
                cnt_b <= cnt_b + 8'd1;
            end
        end
    end

    // A set in the same cycle as a clear wins
    always_ff @(posedge clk) begin
        if (rst) begin
            flag_a <= 1'b0;
            flag_b <= 1'b0;
        end else begin
            if (clr_flag_a) flag_a <= 1'b0;
            if (clr_flag_b) flag_b <= 1'b0;
            if (ovf_a && timer_cfg.en_a) flag_a <= 1'b1;
            if (ovf_b && timer_cfg.en_b) flag_b <= 1'b1;
        end
    end

    assign irq_n = ~(flag_a | flag_b);

endmodule

`default_nettype wire

// File: opn_core.f
design/opn_reg_pkg.sv
design/opn_audio_pkg.sv
design/opn_clkgen.sv
design/opn_regs.sv
design/opn_timers.sv
design/opn_dac.sv
design/opn_core.sv
testbench/tb_opn_core.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the opn_core testbench with Verilator.
# Run from the project root.

LOG=sim.log

verilator --binary --timing -f opn_core.f --top-module tb_opn_core \
    -Mdir obj_dir -o sim_tb_opn_core
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb_opn_core > "$LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$LOG"
    echo "Simulation exited with an error"
    exit 1
fi

cat "$LOG"
if grep -q "TEST RESULT: PASS" "$LOG"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see $LOG"
    exit 1
fi

// File: testbench/tb_opn_core.sv
/*
  Testbench for the reduced FM chip top level, cen held high.
  Samples are 144 clk apart, so the run covers about 110 samples.
  Random values come from an LFSR with a fixed seed.
*/
`timescale 1ns/1ns
`default_nettype none

module tb_opn_core
    import opn_reg_pkg::*, opn_audio_pkg::*;
;

    localparam int TIMEOUT_CYCLES = 30000;  // About 100 samples plus margin

    logic       clk;
    logic       rst;
    logic       cen;
    logic [7:0] din;
    logic [1:0] addr;
    logic       cs_n;
    logic       wr_n;
    logic [7:0] dout;
    logic       irq_n;
    sample_t    snd_left;
    sample_t    snd_right;
    logic       snd_sample;

    logic [31:0] lfsr = 32'h7b8b_5281;
    int          cycles = 0;
    int          checks = 0;
    int          errors = 0;
    int          test_errors = 0;

    opn_core opn_core_inst (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .cen        ( cen        ),
        .din        ( din        ),
        .addr       ( addr       ),
        .cs_n       ( cs_n       ),
        .wr_n       ( wr_n       ),
        .dout       ( dout       ),
        .irq_n      ( irq_n      ),
        .snd_left   ( snd_left   ),
        .snd_right  ( snd_right  ),
        .snd_sample ( snd_sample )
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, a wait never ended", cycles);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // Galois LFSR, polynomial x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // Expected {left, right}, (pcm - 128) * 64 gated by enable and pan
    function automatic logic [31:0] ref_dac(input logic [7:0] pcm, input logic en,
                                            input logic pan_l, input logic pan_r);
        int          s;
        logic [15:0] l;
        logic [15:0] r;
        s = en ? (int'(pcm) - 128) * 64 : 0;
        l = pan_l ? s[15:0] : 16'd0;
        r = pan_r ? s[15:0] : 16'd0;
        return {l, r};
    endfunction

    task automatic compare(input string name, input int expected, input int actual);
        checks++;
        if (expected != actual) begin
            errors++;
            $display("CHECK FAILED %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    // Address cycle, then data cycle, one clk each
    task automatic write_reg(input logic part, input logic [7:0] reg_a, input logic [7:0] data);
        @(posedge clk);
        cs_n <= 1'b0;
        wr_n <= 1'b0;
        addr <= {part, 1'b0};
        din  <= reg_a;
        @(posedge clk);
        addr <= {part, 1'b1};
        din  <= data;
        @(posedge clk);
        cs_n <= 1'b1;
        wr_n <= 1'b1;
    endtask

    task automatic wait_sample();
        do @(negedge clk); while (snd_sample !== 1'b1);
    endtask

    task automatic report_test(input string name);
        if (errors == test_errors) $display("%s: ok", name);
        else $display("%s: %0d errors", name, errors - test_errors);
        test_errors = errors;
    endtask

    task automatic compare_dac(input string name, input logic [31:0] exp_pair);
        compare({name, " left"}, int'($signed(exp_pair[31:16])), int'(snd_left));
        compare({name, " right"}, int'($signed(exp_pair[15:0])), int'(snd_right));
    endtask

    initial begin
        int          n;
        int          expect_n;
        int          seen;
        logic        found;
        logic [7:0]  pcm;
        logic [7:0]  pan;
        logic [9:0]  value_a;

        rst  <= 1'b1;
        cen  <= 1'b1;
        din  <= 8'h00;
        addr <= 2'b00;
        cs_n <= 1'b1;
        wr_n <= 1'b1;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        // Reset state
        @(negedge clk);
        compare("reset dout", 0, int'(dout));
        compare("reset irq_n", 1, int'(irq_n));
        wait_sample();
        compare_dac("reset dac", 32'd0);
        report_test("reset state");

        // Busy lasts 32 clk with cen high
        write_reg(1'b0, REG_DAC_DATA, 8'h80);
        n = 0;
        forever begin
            @(negedge clk);
            if (!dout[7] || n > 100) break;
            n++;
        end
        compare("busy length", 32, n);
        report_test("busy");

        write_reg(1'b0, REG_DAC_EN, 8'h80);
        for (int round = 0; round < 20; round++) begin
            pcm = 8'(take_bits(8));
            pan = {2'(take_bits(2)), 6'd0};
            write_reg(1'b0, REG_DAC_DATA, pcm);
            write_reg(1'b1, REG_PAN_CH6, pan);
            wait_sample();
            wait_sample();
            compare_dac("dac round", ref_dac(pcm, 1'b1, pan[7], pan[6]));
        end
        // Loud byte on both sides, so only the enable can silence it
        write_reg(1'b0, REG_DAC_DATA, 8'h00);
        write_reg(1'b1, REG_PAN_CH6, 8'hC0);
        write_reg(1'b0, REG_DAC_EN, 8'h00);
        wait_sample();
        wait_sample();
        compare_dac("dac disabled", 32'd0);
        report_test("dac path");

        // Part II has no 0x2A, the part I byte must stay
        pcm = 8'(take_bits(8));
        write_reg(1'b0, REG_DAC_EN, 8'h80);
        write_reg(1'b0, REG_DAC_DATA, pcm);
        write_reg(1'b1, REG_PAN_CH6, 8'hC0);
        write_reg(1'b1, REG_DAC_DATA, ~pcm);
        wait_sample();
        wait_sample();
        compare_dac("part II filter", ref_dac(pcm, 1'b1, 1'b1, 1'b1));
        report_test("part II filtering");

        value_a = 10'd1016 + 10'(take_bits(3));
        write_reg(1'b0, REG_TIMER_A_HI, value_a[9:2]);
        write_reg(1'b0, REG_TIMER_A_LO, {6'd0, value_a[1:0]});
        write_reg(1'b0, REG_TIMER_CTRL, 8'h05);  // en_a and load_a
        expect_n = 1024 - int'(value_a);
        n = 0;
        found = 1'b0;
        while (!found && n <= 16) begin
            @(negedge clk);
            if (snd_sample) n++;
            if (dout[0]) found = 1'b1;
        end
        checks++;
        if (!found) begin
            errors++;
            $display("Timer A flag did not rise within 16 samples");
        end else if (n < expect_n - 1 || n > expect_n + 1) begin
            errors++;
            $display("CHECK FAILED timer A samples: expected %0d +/- 1, actual %0d",
                     expect_n, n);
        end
        compare("timer A irq_n", 0, int'(irq_n));
        write_reg(1'b0, REG_TIMER_CTRL, 8'h10);  // reset_a, timer stopped
        @(negedge clk);
        @(negedge clk);
        compare("timer A flag cleared", 0, int'(dout[0]));
        compare("timer A irq_n cleared", 1, int'(irq_n));
        report_test("timer A");

        // Timer B overflows near sample 32 but en_b is off
        write_reg(1'b0, REG_TIMER_B, 8'd254);
        write_reg(1'b0, REG_TIMER_CTRL, 8'h02);
        seen = 0;
        repeat (40) begin
            wait_sample();
            if (dout[1] || !irq_n) seen = 1;
        end
        compare("timer B gated flag", 0, seen);
        write_reg(1'b0, REG_TIMER_CTRL, 8'h0A);  // load_b kept, en_b set
        n = 0;
        found = 1'b0;
        while (!found && n <= 60) begin
            @(negedge clk);
            if (snd_sample) n++;
            if (dout[1]) found = 1'b1;
        end
        checks++;
        if (!found) begin
            errors++;
            $display("Timer B flag did not rise within 60 samples");
        end else if (n < 16 || n > 48) begin
            errors++;
            $display("CHECK FAILED timer B samples: expected 32 +/- 16, actual %0d", n);
        end
        compare("timer B irq_n", 0, int'(irq_n));
        report_test("timer B");

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
